//--- include/nes_glue_config.svh
`ifndef NES_GLUE_CONFIG_SVH
`define NES_GLUE_CONFIG_SVH

// memory port geometry
`define NES_ADDR_W 22 // byte address into game memory
`define NES_DATA_W 8  // one byte per access

// core clock-enable divider
`define NES_CE_W 2 // phase counter width

// staged loader writes go out in this phase only
`define NES_WRITE_PHASE 3

// reset stretches, in clock cycles
`define NES_POR_CYCLES (1 << 23) // power-on hold
`define NES_SETTLE_CYCLES 255    // hold after load completes

// onboard buttons inside the joypad vector
`define JOY_BIT_A 0
`define JOY_BIT_START 3

`endif

//--- design/nes_mem_pkg.sv
`include "nes_glue_config.svh"

package nes_mem_pkg;

  // address into game memory
  typedef logic [`NES_ADDR_W-1:0] mem_addr_t;

  // one memory byte
  typedef logic [`NES_DATA_W-1:0] mem_data_t;

  // phase of the core clock enable
  typedef logic [`NES_CE_W-1:0] ce_phase_t;

endpackage

//--- design/nes_ctrl_pkg.sv
`include "nes_glue_config.svh"

package nes_ctrl_pkg;

  // console bring-up states
  typedef enum logic [2:0] {
    HOLD,      // power-on or forced reset
    WAIT_DATA, // waiting for first loader byte
    LOADING,   // loader owns memory
    SETTLE,    // load done, reset still held
    RUN        // console running
  } boot_state_t;

  // NES order, A shifted out first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } joy_buttons_t;

endpackage

//--- design/reset_timer.sv
`timescale 1ns/1ns

module reset_timer #(
  parameter int CYCLES = 1
) (
  input  logic clock,
  input  logic arst_n_i,
  input  logic restart_i,
  output logic busy_o
);

  localparam int CNT_W = (CYCLES < 1) ? 1 : $clog2(CYCLES + 1);
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CYCLES);

  logic [CNT_W-1:0] count_q;

  // counts down to zero once restart is released
  always_ff @(posedge clock or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      count_q <= RELOAD; // start busy out of reset
    end
    else if (restart_i)
    begin
      count_q <= RELOAD;
    end
    else if (count_q != '0)
    begin
      count_q <= count_q - 1'b1;
    end
  end

  assign busy_o = (count_q != '0);

endmodule

//--- design/boot_sequencer.sv
`timescale 1ns/1ns
`include "nes_glue_config.svh"

module boot_sequencer #(
  parameter int POR_CYCLES    = `NES_POR_CYCLES,
  parameter int SETTLE_CYCLES = `NES_SETTLE_CYCLES
) (
  input  logic clock,
  input  logic arst_n_i,
  input  logic pll_locked_i,
  input  logic usb_reset_i,
  input  logic loader_valid_i,
  input  logic load_done_i,
  output logic reset_nes_o,
  output logic loading_o
);

  import nes_ctrl_pkg::*;

  boot_state_t state_q;
  boot_state_t state_d;
  logic        por_restart;
  logic        por_busy;
  logic        settle_restart;
  logic        settle_busy;
  logic        reset_nes_q;
  logic        loading_q;

  assign por_restart    = !pll_locked_i || usb_reset_i; // lost lock or reset button
  assign settle_restart = !load_done_i;

  reset_timer #(
    .CYCLES (POR_CYCLES)
  ) u_por_timer (
    .clock     (clock),
    .arst_n_i  (arst_n_i),
    .restart_i (por_restart),
    .busy_o    (por_busy)
  );

  reset_timer #(
    .CYCLES (SETTLE_CYCLES)
  ) u_settle_timer (
    .clock     (clock),
    .arst_n_i  (arst_n_i),
    .restart_i (settle_restart),
    .busy_o    (settle_busy)
  );

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      HOLD:
        if (!por_busy)
          state_d = WAIT_DATA;
      WAIT_DATA:
        if (loader_valid_i)
          state_d = LOADING; // first byte seen
      LOADING:
        if (load_done_i)
          state_d = SETTLE;
      SETTLE:
        if (!load_done_i)
          state_d = LOADING;
        else if (!settle_busy)
          state_d = RUN;
      RUN:
        if (!load_done_i)
          state_d = LOADING; // a new load started
      default:
        state_d = HOLD;
    endcase
    if (por_restart)
      state_d = HOLD; // overrides everything
  end

  // outputs trail the state by one cycle, both on the same edge
  always_ff @(posedge clock or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q     <= HOLD;
      reset_nes_q <= 1'b1;
      loading_q   <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      reset_nes_q <= (state_q != RUN);
      loading_q   <= (state_q == WAIT_DATA) || (state_q == LOADING);
    end
  end

  assign reset_nes_o = reset_nes_q;
  assign loading_o   = loading_q;

endmodule

//--- design/loader_write_stage.sv
`timescale 1ns/1ns
`include "nes_glue_config.svh"

module loader_write_stage (
  input  logic                  clock,
  input  logic                  arst_n_i,
  input  logic                  loading_i,
  input  logic                  loader_write_i,
  input  nes_mem_pkg::mem_addr_t loader_addr_i,
  input  nes_mem_pkg::mem_data_t loader_data_i,
  input  nes_mem_pkg::ce_phase_t nes_ce_i,
  input  nes_mem_pkg::mem_addr_t cpu_addr_i,
  input  nes_mem_pkg::mem_data_t cpu_data_i,
  input  logic                  cpu_we_i,
  output nes_mem_pkg::mem_addr_t mem_addr_o,
  output nes_mem_pkg::mem_data_t mem_data_o,
  output logic                  mem_we_o
);

  import nes_mem_pkg::*;

  localparam ce_phase_t WRITE_PHASE = ce_phase_t'(`NES_WRITE_PHASE);

  logic      pending_q;
  logic      issue;
  mem_addr_t held_addr_q;
  mem_data_t held_data_q;

  // held write goes out in the first matching phase slot
  assign issue = pending_q && (nes_ce_i == WRITE_PHASE);

  always_ff @(posedge clock or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pending_q <= 1'b0;
    end
    else if (loader_write_i)
    begin
      pending_q <= 1'b1; // a newer strobe replaces the held one
    end
    else if (issue)
    begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (loader_write_i)
    begin
      held_addr_q <= loader_addr_i;
      held_data_q <= loader_data_i;
    end
  end

  // memory port owner: loader while loading, otherwise the CPU
  always_comb
  begin
    if (loading_i)
    begin
      mem_addr_o = held_addr_q;
      mem_data_o = held_data_q;
      mem_we_o   = issue;
    end
    else
    begin
      mem_addr_o = cpu_addr_i;
      mem_data_o = cpu_data_i;
      mem_we_o   = cpu_we_i;
    end
  end

endmodule

//--- design/joypad_shifter.sv
`timescale 1ns/1ns
`include "nes_glue_config.svh"

module joypad_shifter (
  input  logic                       clock,
  input  logic                       arst_n_i,
  input  logic                       btn_a_i,
  input  logic                       btn_start_i,
  input  logic                       joy_strobe_i,
  input  logic                       joy_clock_i,
  input  nes_ctrl_pkg::joy_buttons_t usb_buttons_i,
  output logic                       joy_data_o
);

  import nes_ctrl_pkg::*;

  logic [1:0]   btn_meta_q; // {start, a}
  logic [1:0]   btn_sync_q;
  logic         joy_clock_q;
  joy_buttons_t onboard;
  joy_buttons_t merged;
  joy_buttons_t shift_q;

  always_comb
  begin
    onboard                 = '0;
    onboard[`JOY_BIT_A]     = btn_sync_q[0];
    onboard[`JOY_BIT_START] = btn_sync_q[1];
    merged                  = onboard | usb_buttons_i;
  end

  always_ff @(posedge clock or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      btn_meta_q  <= '0;
      btn_sync_q  <= '0;
      joy_clock_q <= 1'b0;
      shift_q     <= '0;
    end
    else
    begin
      btn_meta_q  <= {btn_start_i, btn_a_i}; // pins are asynchronous
      btn_sync_q  <= btn_meta_q;
      joy_clock_q <= joy_clock_i;
      if (joy_strobe_i)
        shift_q <= merged;
      else if (!joy_clock_i && joy_clock_q)
        shift_q <= {1'b0, shift_q[$bits(joy_buttons_t)-1:1]}; // falling edge of joypad clock
    end
  end

  assign joy_data_o = shift_q[0];

endmodule

//--- design/nes_glue_top.sv
`timescale 1ns/1ns
`include "nes_glue_config.svh"

module nes_glue_top #(
  parameter int POR_CYCLES    = `NES_POR_CYCLES,
  parameter int SETTLE_CYCLES = `NES_SETTLE_CYCLES
) (
  input  logic                       clock,
  input  logic                       arst_n_i,
  input  logic                       pll_locked_i,
  input  logic                       usb_reset_i,
  input  logic                       loader_valid_i,
  input  logic                       load_done_i,
  input  logic                       loader_write_i,
  input  nes_mem_pkg::mem_addr_t     loader_addr_i,
  input  nes_mem_pkg::mem_data_t     loader_data_i,
  input  nes_mem_pkg::ce_phase_t     nes_ce_i,
  input  nes_mem_pkg::mem_addr_t     cpu_addr_i,
  input  nes_mem_pkg::mem_data_t     cpu_data_i,
  input  logic                       cpu_we_i,
  output nes_mem_pkg::mem_addr_t     mem_addr_o,
  output nes_mem_pkg::mem_data_t     mem_data_o,
  output logic                       mem_we_o,
  input  logic                       btn_a_i,
  input  logic                       btn_start_i,
  input  nes_ctrl_pkg::joy_buttons_t usb_buttons_i,
  input  logic                       joy_strobe_i,
  input  logic                       joy_clock_i,
  output logic                       joy_data_o,
  output logic                       reset_nes_o
);

  logic loading; // loader owns the memory port

  boot_sequencer #(
    .POR_CYCLES    (POR_CYCLES),
    .SETTLE_CYCLES (SETTLE_CYCLES)
  ) i_boot_sequencer (
    .clock          (clock),
    .arst_n_i       (arst_n_i),
    .pll_locked_i   (pll_locked_i),
    .usb_reset_i    (usb_reset_i),
    .loader_valid_i (loader_valid_i),
    .load_done_i    (load_done_i),
    .reset_nes_o    (reset_nes_o),
    .loading_o      (loading)
  );

  loader_write_stage i_loader_write_stage (
    .clock          (clock),
    .arst_n_i       (arst_n_i),
    .loading_i      (loading),
    .loader_write_i (loader_write_i),
    .loader_addr_i  (loader_addr_i),
    .loader_data_i  (loader_data_i),
    .nes_ce_i       (nes_ce_i),
    .cpu_addr_i     (cpu_addr_i),
    .cpu_data_i     (cpu_data_i),
    .cpu_we_i       (cpu_we_i),
    .mem_addr_o     (mem_addr_o),
    .mem_data_o     (mem_data_o),
    .mem_we_o       (mem_we_o)
  );

  joypad_shifter i_joypad_shifter (
    .clock         (clock),
    .arst_n_i      (arst_n_i),
    .btn_a_i       (btn_a_i),
    .btn_start_i   (btn_start_i),
    .joy_strobe_i  (joy_strobe_i),
    .joy_clock_i   (joy_clock_i),
    .usb_buttons_i (usb_buttons_i),
    .joy_data_o    (joy_data_o)
  );

endmodule

//--- testbench/nes_glue_assertions.sv
`timescale 1ns/1ns

module nes_glue_assertions (
  input logic clock,
  input logic arst_n_i,
  input logic loading_i,
  input logic mem_we_i,
  input logic reset_nes_i
);

  int unsigned fail_count = 0; // failed assertions so far

  // staged loader write is a single pulse
  single_write_pulse: assert property (@(posedge clock) disable iff (!arst_n_i)
    (loading_i && mem_we_i) |=> !(loading_i && mem_we_i))
  else
  begin
    fail_count++;
    $error("mem_we_o high for two cycles while loading");
  end

  // console never runs while the loader owns memory
  reset_while_loading: assert property (@(posedge clock) disable iff (!arst_n_i)
    loading_i |-> reset_nes_i)
  else
  begin
    fail_count++;
    $error("reset_nes_o low while loading");
  end

endmodule

bind nes_glue_top nes_glue_assertions i_nes_glue_assertions (
  .clock       (clock),
  .arst_n_i    (arst_n_i),
  .loading_i   (loading),
  .mem_we_i    (mem_we_o),
  .reset_nes_i (reset_nes_o)
);

//--- testbench/nes_glue_tb.sv
`timescale 1ns/1ns
`include "nes_glue_config.svh"

module nes_glue_tb;

  import nes_mem_pkg::*;
  import nes_ctrl_pkg::*;

  localparam ce_phase_t WRITE_PHASE = ce_phase_t'(`NES_WRITE_PHASE);
  localparam int        N_WRITES    = 24;

  logic         clock;
  logic         arst_n_i;
  logic         pll_locked_i;
  logic         usb_reset_i;
  logic         loader_valid_i;
  logic         load_done_i;
  logic         loader_write_i;
  mem_addr_t    loader_addr_i;
  mem_data_t    loader_data_i;
  ce_phase_t    nes_ce_i;
  mem_addr_t    cpu_addr_i;
  mem_data_t    cpu_data_i;
  logic         cpu_we_i;
  mem_addr_t    mem_addr_o;
  mem_data_t    mem_data_o;
  logic         mem_we_o;
  logic         btn_a_i;
  logic         btn_start_i;
  joy_buttons_t usb_buttons_i;
  logic         joy_strobe_i;
  logic         joy_clock_i;
  logic         joy_data_o;
  logic         reset_nes_o;

  logic      model_pending; // reference copy of the held loader write
  mem_addr_t model_addr;
  mem_data_t model_data;
  int        cycles;
  int        gap;

  nes_glue_top #(
    .POR_CYCLES    (20),
    .SETTLE_CYCLES (8)
  ) i_nes_glue_top (.*);

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock)
  begin
    #10;
    nes_ce_i <= nes_ce_i + 1'b1; // free-running core phase
  end

  always @(negedge clock)
    if (i_nes_glue_top.i_nes_glue_assertions.fail_count != 0)
      abort_run("a bound assertion on the DUT failed");

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
    if (got !== exp)
      abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_data(input string name, input mem_data_t got, input mem_data_t exp);
    if (got !== exp)
      abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // moves to the drive point and records a strobe captured on this edge
  task automatic next_cycle();
    @(posedge clock);
    #10;
    if (loader_write_i)
    begin
      model_pending = 1'b1;
      model_addr    = loader_addr_i;
      model_data    = loader_data_i;
    end
  endtask

  task automatic drive_cpu();
    cpu_addr_i = mem_addr_t'($urandom());
    cpu_data_i = mem_data_t'($urandom());
    cpu_we_i   = 1'($urandom());
  endtask

  task automatic run_cycle(input logic exp_reset, input logic check_mem);
    next_cycle();
    drive_cpu();
    @(negedge clock);
    check_bit("reset_nes_o", reset_nes_o, exp_reset);
    if (check_mem)
    begin
      check_addr("mem_addr_o", mem_addr_o, cpu_addr_i); // CPU passes straight through
      check_data("mem_data_o", mem_data_o, cpu_data_i);
      check_bit("mem_we_o", mem_we_o, cpu_we_i);
    end
  endtask

  task automatic loader_cycle(input logic do_write);
    logic expect_we;
    next_cycle();
    loader_write_i = do_write;
    loader_addr_i  = mem_addr_t'($urandom());
    loader_data_i  = mem_data_t'($urandom());
    drive_cpu(); // must not reach the memory port
    @(negedge clock);
    expect_we = model_pending && (nes_ce_i == WRITE_PHASE);
    check_bit("mem_we_o", mem_we_o, expect_we);
    check_bit("reset_nes_o", reset_nes_o, 1'b1);
    if (expect_we)
    begin
      check_addr("mem_addr_o", mem_addr_o, model_addr);
      check_data("mem_data_o", mem_data_o, model_data);
      model_pending = 1'b0;
    end
  endtask

  // counts cycles from the current drive point until reset_nes_o matches
  task automatic wait_reset_level(input logic level, input int limit);
    cycles = 0;
    @(negedge clock);
    while (reset_nes_o !== level)
    begin
      cycles++;
      if (cycles > limit)
        abort_run($sformatf("reset_nes_o did not become %0b within %0d cycles", level, limit));
      next_cycle();
      @(negedge clock);
    end
  endtask

  task automatic joypad_round();
    joy_buttons_t usb;
    joy_buttons_t expect_bits;
    logic         btn_a;
    logic         btn_start;
    next_cycle();
    btn_a         = 1'($urandom());
    btn_start     = 1'($urandom());
    usb           = joy_buttons_t'(8'($urandom()));
    btn_a_i       = btn_a;
    btn_start_i   = btn_start;
    usb_buttons_i = usb;
    expect_bits                 = usb;
    expect_bits[`JOY_BIT_A]     = usb[`JOY_BIT_A] | btn_a;
    expect_bits[`JOY_BIT_START] = usb[`JOY_BIT_START] | btn_start;
    repeat (3) next_cycle(); // two synchronizer flops plus margin
    joy_strobe_i = 1'b1;
    next_cycle();
    joy_strobe_i = 1'b0;
    @(negedge clock);
    check_bit("joy_data_o", joy_data_o, expect_bits[0]);
    for (int i = 1; i < 12; i++)
    begin
      next_cycle();
      joy_clock_i = 1'b1;
      next_cycle();
      joy_clock_i = 1'b0; // shift on the following edge
      next_cycle();
      @(negedge clock);
      check_bit("joy_data_o", joy_data_o, (i < 8) ? expect_bits[i] : 1'b0);
    end
  endtask

  initial
  begin
    void'($urandom(32'hdba1));
    arst_n_i       = 1'b0;
    pll_locked_i   = 1'b1;
    usb_reset_i    = 1'b0;
    loader_valid_i = 1'b0;
    load_done_i    = 1'b0;
    loader_write_i = 1'b0;
    loader_addr_i  = '0;
    loader_data_i  = '0;
    nes_ce_i       = '0;
    cpu_addr_i     = '0;
    cpu_data_i     = '0;
    cpu_we_i       = 1'b0;
    btn_a_i        = 1'b0;
    btn_start_i    = 1'b0;
    usb_buttons_i  = '0;
    joy_strobe_i   = 1'b0;
    joy_clock_i    = 1'b0;
    model_pending  = 1'b0;
    repeat (3) next_cycle();
    arst_n_i = 1'b1;

    repeat (30) run_cycle(1'b1, 1'b0); // past the power-on stretch
    next_cycle();
    loader_valid_i = 1'b1;
    next_cycle();
    loader_valid_i = 1'b0;
    repeat (3) loader_cycle(1'b0);
    repeat (N_WRITES)
    begin
      loader_cycle(1'b1);
      gap = $urandom_range(4, 8);
      repeat (gap - 1) loader_cycle(1'b0);
    end
    cycles = 0;
    while (model_pending)
    begin
      cycles++;
      if (cycles > 8)
        abort_run("a loader write was never issued to memory");
      loader_cycle(1'b0);
    end

    next_cycle();
    load_done_i = 1'b1;
    wait_reset_level(1'b0, 14);
    if (cycles < 8)
      abort_run($sformatf("console left reset after only %0d cycles", cycles));
    repeat (40) run_cycle(1'b0, 1'b1);
    repeat (6) joypad_round();

    next_cycle();
    usb_reset_i = 1'b1;
    wait_reset_level(1'b1, 3);
    repeat (4) run_cycle(1'b1, 1'b0);
    next_cycle();
    usb_reset_i = 1'b0;
    repeat (30) run_cycle(1'b1, 1'b0);
    next_cycle();
    loader_valid_i = 1'b1; // load_done_i still high so settle is short
    next_cycle();
    loader_valid_i = 1'b0;
    wait_reset_level(1'b0, 10);
    next_cycle();
    pll_locked_i = 1'b0;
    wait_reset_level(1'b1, 3);

    if (i_nes_glue_top.i_nes_glue_assertions.fail_count == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
      abort_run("a bound assertion on the DUT failed");
  end

endmodule

//--- nes_glue.f
+incdir+include
design/nes_mem_pkg.sv
design/nes_ctrl_pkg.sv
design/reset_timer.sv
design/boot_sequencer.sv
design/loader_write_stage.sv
design/joypad_shifter.sv
design/nes_glue_top.sv
testbench/nes_glue_assertions.sv
testbench/nes_glue_tb.sv
